/* logic/l2_pkg.sv */
package l2_pkg;

    ////////////////////////////////////////////////
    // fixed geometry
    ////////////////////////////////////////////////

    localparam int way_num        = 4;   // plru tree is built for 4 ways
    localparam int words_per_line = 4;
    localparam int word_off_w     = 2;

    typedef logic [31:0] word_t;
    typedef word_t [words_per_line-1:0] line_t;  // word 0 in the low bits

    typedef logic [way_num-1:0] way_oh_t;
    typedef logic [1:0]         way_idx_t;

    ////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////

    typedef enum logic [1:0] {
        src_none   = 2'd0,
        src_icache = 2'd1,
        src_dcache = 2'd2
    } l2_src_e;

    typedef enum logic [1:0] {
        op_index_inv    = 2'd0,
        op_index_wb_inv = 2'd1,
        op_hit_wb_inv   = 2'd2
    } l2_op_e;

    typedef enum logic [3:0] {
        st_idle,
        st_lookup,
        st_operation,
        st_check_dirty,
        st_check_dirty1,
        st_writeback,
        st_refill_req,
        st_refill_wait
    } l2_state_e;

    // one accepted transaction
    typedef struct packed {
        l2_src_e     src;
        logic        wr;
        logic        is_op;
        l2_op_e      op;
        logic [31:0] addr;    // op_addr for operations
        word_t       wdata;
    } l2_req_t;

endpackage

/* logic/l2_req_buf.sv */
`timescale 1ns/1ps

module l2_req_buf #(
    parameter int index_width = 8
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            we,
    input  l2_pkg::l2_req_t nreq,
    output l2_pkg::l2_req_t req
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req.src   <= l2_pkg::src_none;
            req.is_op <= 1'b0;
        end else if (we) begin
            req.src   <= nreq.src;
            req.is_op <= nreq.is_op;
        end
    end

    // payload held for the whole transaction
    always_ff @(posedge clk) begin
        if (we) begin
            req.wr    <= nreq.wr;
            req.op    <= nreq.op;
            req.addr  <= nreq.addr;
            req.wdata <= nreq.wdata;
        end
    end

    // an accept must always come from a real port
    a_we_has_src: assert property (@(posedge clk) disable iff (!rstn)
        we |-> (nreq.src != l2_pkg::src_none) || nreq.is_op);

endmodule

/* logic/l2_plru.sv */
`timescale 1ns/1ps

module l2_plru #(
    parameter int index_width = 8
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] index,
    input  logic                   use_we,
    input  l2_pkg::way_idx_t       use_way,
    output l2_pkg::way_idx_t       victim
);

    localparam int sets = 2 ** index_width;

    // bit 0 root, bit 1 picks in ways 0/1, bit 2 in ways 2/3
    logic [2:0] tree [sets];
    logic [2:0] cur;
    logic [2:0] upd;

    assign cur = tree[index];

    // follow the tree to the way it points at
    always_comb begin
        if (!cur[0]) begin
            victim = {1'b0, cur[1]};
        end else begin
            victim = {1'b1, cur[2]};
        end
    end

    // turn every node on the path away from the used way
    always_comb begin
        upd    = cur;
        upd[0] = ~use_way[1];
        if (!use_way[1]) begin
            upd[1] = ~use_way[0];
        end else begin
            upd[2] = ~use_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < sets; s++) begin
                tree[s] <= 3'b000;
            end
        end else if (use_we) begin
            tree[index] <= upd;
        end
    end

endmodule

/* logic/l2_tag_store.sv */
`timescale 1ns/1ps

module l2_tag_store #(
    parameter int index_width = 8
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  l2_pkg::l2_req_t              req,
    input  l2_pkg::way_idx_t             sel_way,
    input  logic                         tag_we,
    input  logic                         tag_inv,
    input  logic                         dirty_set,
    input  logic                         dirty_clr,
    output l2_pkg::way_oh_t              hit,
    output logic                         dirty,
    output logic [27-index_width:0]      victim_tag
);

    localparam int sets  = 2 ** index_width;
    localparam int tag_w = 28 - index_width;

    logic [tag_w-1:0] tag_arr [l2_pkg::way_num][sets];
    l2_pkg::way_oh_t  valid_arr [sets];
    l2_pkg::way_oh_t  dirty_arr [sets];

    logic [index_width-1:0] idx;
    logic [tag_w-1:0]       req_tag;

    assign idx     = req.addr[index_width+3:4];
    assign req_tag = req.addr[31:index_width+4];

    // parallel compare of all ways
    always_comb begin
        for (int w = 0; w < l2_pkg::way_num; w++) begin
            hit[w] = valid_arr[idx][w] && (tag_arr[w][idx] == req_tag);
        end
    end

    assign dirty      = dirty_arr[idx][sel_way];
    assign victim_tag = tag_arr[sel_way][idx];  // address of the line to write back

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_arr[sel_way][idx] <= req_tag;
        end
    end

    ////////////////////////////////////////////////
    // valid and dirty bits
    ////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < sets; s++) begin
                valid_arr[s] <= '0;
                dirty_arr[s] <= '0;
            end
        end else begin
            if (tag_we) valid_arr[idx][sel_way] <= 1'b1;
            else if (tag_inv) valid_arr[idx][sel_way] <= 1'b0;
            if (dirty_set) dirty_arr[idx][sel_way] <= 1'b1;
            else if (dirty_clr) dirty_arr[idx][sel_way] <= 1'b0;
        end
    end

    // a tag may live in one way of a set only
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(hit));

endmodule

/* logic/l2_data_store.sv */
`timescale 1ns/1ps

module l2_data_store #(
    parameter int index_width = 8
) (
    input  logic             clk,
    input  l2_pkg::l2_req_t  req,
    input  l2_pkg::way_idx_t sel_way,
    input  logic             data_we,
    input  logic             data_refill,
    input  l2_pkg::line_t    rline,
    output l2_pkg::word_t    rword,
    output l2_pkg::line_t    wb_line
);

    localparam int sets = 2 ** index_width;

    l2_pkg::line_t lines [l2_pkg::way_num][sets];

    logic [index_width-1:0]        idx;
    logic [l2_pkg::word_off_w-1:0] off;
    l2_pkg::line_t                 fill_line;
    l2_pkg::line_t                 cur_line;

    assign idx      = req.addr[index_width+3:4];
    assign off      = req.addr[3:2];
    assign cur_line = lines[sel_way][idx];

    // refill line with the pending store word merged in
    always_comb begin
        fill_line = rline;
        if (req.wr) begin
            fill_line[off] = req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (data_refill) begin
            lines[sel_way][idx] <= fill_line;
        end else if (data_we) begin
            lines[sel_way][idx][off] <= req.wdata;
        end
    end

    // bypass from memory so data_ok can go with mem_data_ok
    assign rword   = data_refill ? rline[off] : cur_line[off];
    assign wb_line = cur_line;

endmodule

/* logic/l2_fsm_main.sv */
`timescale 1ns/1ps

module l2_fsm_main (
    input  logic             clk,
    input  logic             rstn,
    input  logic             icache_req,
    input  logic             dcache_req,
    input  logic             op_flag,
    output logic             icache_addr_ok,
    output logic             dcache_addr_ok,
    output logic             op_ack,
    output logic             icache_data_ok,
    output logic             dcache_data_ok,
    output logic             buf_we,
    input  l2_pkg::l2_req_t  req,
    input  l2_pkg::way_oh_t  hit,
    input  logic             dirty,
    input  l2_pkg::way_idx_t victim,
    output logic             use_we,
    output l2_pkg::way_idx_t use_way,
    output l2_pkg::way_idx_t sel_way,
    output logic             tag_we,
    output logic             tag_inv,
    output logic             dirty_set,
    output logic             dirty_clr,
    output logic             data_we,
    output logic             data_refill,
    output logic             mem_req_r,
    output logic             mem_req_w,
    output logic             mem_rdy,
    input  logic             mem_addr_ok_r,
    input  logic             mem_addr_ok_w,
    input  logic             mem_data_ok
);

    l2_pkg::l2_state_e state;
    l2_pkg::l2_state_e state_nx;

    l2_pkg::way_idx_t way_q;    // way under writeback / refill
    l2_pkg::way_idx_t way_d;
    l2_pkg::way_idx_t hit_way;
    logic             way_ld;
    logic             any_hit;
    logic             data_ok;

    assign any_hit = |hit;

    always_comb begin
        hit_way = '0;
        for (int w = l2_pkg::way_num - 1; w >= 0; w--) begin
            if (hit[w]) hit_way = l2_pkg::way_idx_t'(w);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) state <= l2_pkg::st_idle;
        else state <= state_nx;
    end

    always_ff @(posedge clk) begin
        if (way_ld) way_q <= way_d;
    end

    ////////////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////////////

    always_comb begin
        state_nx       = state;
        icache_addr_ok = 1'b0;
        dcache_addr_ok = 1'b0;
        op_ack         = 1'b0;
        buf_we         = 1'b0;
        data_ok        = 1'b0;
        use_we         = 1'b0;
        use_way        = way_q;
        sel_way        = way_q;
        tag_we         = 1'b0;
        tag_inv        = 1'b0;
        dirty_set      = 1'b0;
        dirty_clr      = 1'b0;
        data_we        = 1'b0;
        data_refill    = 1'b0;
        mem_req_r      = 1'b0;
        mem_req_w      = 1'b0;
        mem_rdy        = 1'b0;
        way_ld         = 1'b0;
        way_d          = victim;
        case (state)
            l2_pkg::st_idle: begin
                buf_we = op_flag | dcache_req | icache_req;
                if (op_flag) begin                 // operations win
                    op_ack   = 1'b1;
                    state_nx = l2_pkg::st_operation;
                end else if (dcache_req) begin
                    dcache_addr_ok = 1'b1;
                    state_nx       = l2_pkg::st_lookup;
                end else if (icache_req) begin
                    icache_addr_ok = 1'b1;
                    state_nx       = l2_pkg::st_lookup;
                end
            end
            l2_pkg::st_lookup: begin
                sel_way = hit_way;
                use_way = hit_way;
                if (any_hit) begin
                    use_we    = 1'b1;
                    data_we   = req.wr;
                    dirty_set = req.wr;
                    data_ok   = !req.wr;
                    state_nx  = l2_pkg::st_idle;
                end else begin
                    state_nx = l2_pkg::st_check_dirty;
                end
            end
            l2_pkg::st_operation: begin
                state_nx = l2_pkg::st_idle;
                case (req.op)
                    l2_pkg::op_index_inv: begin
                        sel_way   = req.addr[1:0];
                        tag_inv   = 1'b1;
                        dirty_clr = 1'b1;          // dropped without writeback
                    end
                    l2_pkg::op_index_wb_inv: begin
                        sel_way  = req.addr[1:0];
                        tag_inv  = 1'b1;
                        way_ld   = 1'b1;
                        way_d    = req.addr[1:0];
                        state_nx = l2_pkg::st_check_dirty;
                    end
                    l2_pkg::op_hit_wb_inv: begin
                        if (any_hit) begin
                            sel_way  = hit_way;
                            tag_inv  = 1'b1;
                            way_ld   = 1'b1;
                            way_d    = hit_way;    // record hit way
                            state_nx = l2_pkg::st_check_dirty;
                        end
                    end
                    default: ;
                endcase
            end
            l2_pkg::st_check_dirty: begin
                way_ld   = !req.is_op;             // freeze plru victim
                state_nx = l2_pkg::st_check_dirty1;
            end
            l2_pkg::st_check_dirty1: begin
                if (dirty) state_nx = l2_pkg::st_writeback;
                else if (req.is_op) state_nx = l2_pkg::st_idle;
                else state_nx = l2_pkg::st_refill_req;
            end
            l2_pkg::st_writeback: begin
                mem_req_w = 1'b1;
                if (mem_addr_ok_w) begin
                    dirty_clr = 1'b1;
                    state_nx  = req.is_op ? l2_pkg::st_idle : l2_pkg::st_refill_req;
                end
            end
            l2_pkg::st_refill_req: begin
                mem_req_r = 1'b1;
                if (mem_addr_ok_r) state_nx = l2_pkg::st_refill_wait;
            end
            l2_pkg::st_refill_wait: begin
                mem_rdy = 1'b1;
                if (mem_data_ok) begin
                    data_refill = 1'b1;
                    tag_we      = 1'b1;
                    use_we      = 1'b1;
                    dirty_set   = req.wr;          // store merged into the line
                    dirty_clr   = !req.wr;
                    data_ok     = !req.wr;
                    state_nx    = l2_pkg::st_idle;
                end
            end
            default: state_nx = l2_pkg::st_idle;
        endcase
        icache_data_ok = data_ok && (req.src == l2_pkg::src_icache);
        dcache_data_ok = data_ok && (req.src == l2_pkg::src_dcache);
    end

    a_mem_req_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_req_r && mem_req_w));

    a_data_ok_state: assert property (@(posedge clk) disable iff (!rstn)
        (icache_data_ok || dcache_data_ok) |->
            (state == l2_pkg::st_lookup) || (state == l2_pkg::st_refill_wait));

endmodule

/* logic/l2_cache.sv */
`timescale 1ns/1ps

module l2_cache #(
    parameter int index_width = 8
) (
    input  logic           clk,
    input  logic           rstn,
    // icache port
    input  logic           icache_req,
    input  logic [31:0]    icache_addr,
    output logic           icache_addr_ok,
    output logic           icache_data_ok,
    output l2_pkg::word_t  icache_rdata,
    // dcache port
    input  logic           dcache_req,
    input  logic           dcache_wr,
    input  logic [31:0]    dcache_addr,
    input  l2_pkg::word_t  dcache_wdata,
    output logic           dcache_addr_ok,
    output logic           dcache_data_ok,
    output l2_pkg::word_t  dcache_rdata,
    // cache operations
    input  logic           op_flag,
    input  l2_pkg::l2_op_e op_code,
    input  logic [31:0]    op_addr,
    output logic           op_ack,
    // memory read channel
    output logic           mem_req_r,
    output logic [31:0]    mem_raddr,
    input  logic           mem_addr_ok_r,
    output logic           mem_rdy,
    input  logic           mem_data_ok,
    input  l2_pkg::line_t  mem_rline,
    // memory write channel
    output logic           mem_req_w,
    output logic [31:0]    mem_waddr,
    output l2_pkg::line_t  mem_wline,
    input  logic           mem_addr_ok_w
);

    l2_pkg::l2_req_t        nreq;
    l2_pkg::l2_req_t        req;
    logic                   buf_we;
    l2_pkg::way_oh_t        hit;
    logic                   dirty;
    logic [27-index_width:0] victim_tag;
    l2_pkg::way_idx_t       victim;
    logic                   use_we;
    l2_pkg::way_idx_t       use_way;
    l2_pkg::way_idx_t       sel_way;
    logic                   tag_we;
    logic                   tag_inv;
    logic                   dirty_set;
    logic                   dirty_clr;
    logic                   data_we;
    logic                   data_refill;
    l2_pkg::word_t          rword;
    logic [index_width-1:0] set_idx;

    // candidate request, same priority as the fsm accept
    assign nreq = op_flag ?
        '{src: l2_pkg::src_none, wr: 1'b0, is_op: 1'b1, op: op_code,
          addr: op_addr, wdata: dcache_wdata} :
        dcache_req ?
        '{src: l2_pkg::src_dcache, wr: dcache_wr, is_op: 1'b0, op: l2_pkg::op_index_inv,
          addr: dcache_addr, wdata: dcache_wdata} :
        '{src: icache_req ? l2_pkg::src_icache : l2_pkg::src_none, wr: 1'b0, is_op: 1'b0,
          op: l2_pkg::op_index_inv, addr: icache_addr, wdata: dcache_wdata};

    assign set_idx      = req.addr[index_width+3:4];
    assign mem_raddr    = {req.addr[31:4], 4'b0000};     // line aligned
    assign mem_waddr    = {victim_tag, set_idx, 4'b0000};
    assign icache_rdata = rword;
    assign dcache_rdata = rword;

    l2_fsm_main i_fsm (
        .clk, .rstn,
        .icache_req, .dcache_req, .op_flag,
        .icache_addr_ok, .dcache_addr_ok, .op_ack, .icache_data_ok, .dcache_data_ok,
        .buf_we, .req, .hit, .dirty, .victim,
        .use_we, .use_way, .sel_way,
        .tag_we, .tag_inv, .dirty_set, .dirty_clr, .data_we, .data_refill,
        .mem_req_r, .mem_req_w, .mem_rdy,
        .mem_addr_ok_r, .mem_addr_ok_w, .mem_data_ok
    );

    l2_req_buf #(.index_width(index_width)) i_req_buf (
        .clk, .rstn, .we(buf_we), .nreq, .req
    );

    l2_plru #(.index_width(index_width)) i_plru (
        .clk, .rstn, .index(set_idx), .use_we, .use_way, .victim
    );

    l2_tag_store #(.index_width(index_width)) i_tag_store (
        .clk, .rstn, .req, .sel_way,
        .tag_we, .tag_inv, .dirty_set, .dirty_clr,
        .hit, .dirty, .victim_tag
    );

    l2_data_store #(.index_width(index_width)) i_data_store (
        .clk, .req, .sel_way, .data_we, .data_refill,
        .rline(mem_rline), .rword, .wb_line(mem_wline)
    );

endmodule

/* tb/tb_l2_cache.sv */
`timescale 1ns/1ps

module tb_l2_cache;

    localparam int index_width       = 2;    // 4 sets for frequent conflicts
    localparam int n_random          = 300;
    localparam int n_requests        = n_random + 80;
    localparam int worst_miss_cycles = 24;   // writeback + refill at max memory delay
    localparam int timeout_ns        = (10 + 2 * n_requests * worst_miss_cycles) * 10;

    logic           clk = 1'b0;
    logic           rstn;
    logic           icache_req;
    logic [31:0]    icache_addr;
    logic           icache_addr_ok;
    logic           icache_data_ok;
    l2_pkg::word_t  icache_rdata;
    logic           dcache_req;
    logic           dcache_wr;
    logic [31:0]    dcache_addr;
    l2_pkg::word_t  dcache_wdata;
    logic           dcache_addr_ok;
    logic           dcache_data_ok;
    l2_pkg::word_t  dcache_rdata;
    logic           op_flag;
    l2_pkg::l2_op_e op_code;
    logic [31:0]    op_addr;
    logic           op_ack;
    logic           mem_req_r;
    logic [31:0]    mem_raddr;
    logic           mem_addr_ok_r;
    logic           mem_rdy;
    logic           mem_data_ok;
    l2_pkg::line_t  mem_rline;
    logic           mem_req_w;
    logic [31:0]    mem_waddr;
    l2_pkg::line_t  mem_wline;
    logic           mem_addr_ok_w;

    l2_pkg::line_t  mem_arr [64];   // backing memory of 1 KB
    l2_pkg::word_t  ref_mem [256];  // latest value of every word
    logic [31:0]    raddr;
    int             n_checks  = 0;
    int             n_errors  = 0;
    int             test_base = 0;
    int             rd_count  = 0;
    int             wb_count  = 0;

    l2_cache #(.index_width(index_width)) i_l2_cache (
        .clk, .rstn,
        .icache_req, .icache_addr, .icache_addr_ok, .icache_data_ok, .icache_rdata,
        .dcache_req, .dcache_wr, .dcache_addr, .dcache_wdata,
        .dcache_addr_ok, .dcache_data_ok, .dcache_rdata,
        .op_flag, .op_code, .op_addr, .op_ack,
        .mem_req_r, .mem_raddr, .mem_addr_ok_r, .mem_rdy, .mem_data_ok, .mem_rline,
        .mem_req_w, .mem_waddr, .mem_wline, .mem_addr_ok_w
    );

    always #5 clk = ~clk;

    function automatic l2_pkg::word_t pattern(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;  // odd multiplier keeps every bit
    endfunction

    function automatic l2_pkg::line_t model_line(input logic [31:0] addr);
        l2_pkg::line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k] = ref_mem[{addr[9:4], 2'(k)}];
        end
        return l;
    endfunction

    ////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////

    task automatic check_word(input string name, input l2_pkg::word_t got,
                              input l2_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input l2_pkg::line_t got,
                              input l2_pkg::line_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic close_test(input int num, input string name);
        if (n_errors == test_base) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, n_errors - test_base);
        end
        test_base = n_errors;
    endtask

    ////////////////////////////////////////////////
    // port drivers
    ////////////////////////////////////////////////

    // outputs are settled 1 ns after the falling edge
    task automatic next_cycle();
        @(negedge clk);
        #1;
    endtask

    task automatic icache_read(input logic [31:0] addr);
        l2_pkg::word_t exp;
        exp = ref_mem[addr[9:2]];
        @(negedge clk);
        icache_req  = 1'b1;
        icache_addr = addr;
        #1;
        while (!icache_addr_ok) next_cycle();
        @(negedge clk);
        icache_req = 1'b0;
        #1;
        while (!icache_data_ok) next_cycle();
        check_word("icache_rdata", icache_rdata, exp);
    endtask

    task automatic dcache_access(input logic wr, input logic [31:0] addr,
                                 input l2_pkg::word_t wdata);
        l2_pkg::word_t exp;
        exp = ref_mem[addr[9:2]];
        @(negedge clk);
        dcache_req   = 1'b1;
        dcache_wr    = wr;
        dcache_addr  = addr;
        dcache_wdata = wdata;
        #1;
        while (!dcache_addr_ok) next_cycle();
        @(negedge clk);
        dcache_req = 1'b0;
        dcache_wr  = 1'b0;
        #1;
        if (wr) begin
            ref_mem[addr[9:2]] = wdata;   // writes finish without data_ok
        end else begin
            while (!dcache_data_ok) next_cycle();
            check_word("dcache_rdata", dcache_rdata, exp);
        end
    endtask

    task automatic cache_op(input l2_pkg::l2_op_e code, input logic [31:0] addr);
        @(negedge clk);
        op_flag = 1'b1;
        op_code = code;
        op_addr = addr;
        #1;
        while (!op_ack) next_cycle();
        @(negedge clk);
        op_flag = 1'b0;
    endtask

    // ack of a harmless op on a never cached line means the controller went idle
    task automatic settle();
        cache_op(l2_pkg::op_hit_wb_inv, 32'h0001_0000);
    endtask

    task automatic dual_request(input logic [31:0] daddr, input logic [31:0] iaddr);
        l2_pkg::word_t dexp;
        l2_pkg::word_t iexp;
        dexp = ref_mem[daddr[9:2]];
        iexp = ref_mem[iaddr[9:2]];
        @(negedge clk);
        dcache_req  = 1'b1;
        dcache_wr   = 1'b0;
        dcache_addr = daddr;
        icache_req  = 1'b1;
        icache_addr = iaddr;
        #1;
        while (!(dcache_addr_ok || icache_addr_ok)) next_cycle();
        check_bit("dcache_addr_ok", dcache_addr_ok, 1'b1);
        check_bit("icache_addr_ok", icache_addr_ok, 1'b0);
        @(negedge clk);
        dcache_req = 1'b0;
        #1;
        while (!dcache_data_ok) next_cycle();
        check_word("dcache_rdata", dcache_rdata, dexp);
        while (!icache_addr_ok) next_cycle();   // icache held until served
        @(negedge clk);
        icache_req = 1'b0;
        #1;
        while (!icache_data_ok) next_cycle();
        check_word("icache_rdata", icache_rdata, iexp);
    endtask

    ////////////////////////////////////////////////
    // memory responder
    ////////////////////////////////////////////////

    initial begin
        forever begin
            @(negedge clk);
            if (mem_req_w) begin
                repeat ($urandom % 4) @(negedge clk);
                mem_addr_ok_w = 1'b1;
                check_line("mem_wline", mem_wline, model_line(mem_waddr));
                mem_arr[mem_waddr[9:4]] = mem_wline;
                wb_count++;
                @(negedge clk);
                mem_addr_ok_w = 1'b0;
            end else if (mem_req_r) begin
                repeat ($urandom % 4) @(negedge clk);
                mem_addr_ok_r = 1'b1;
                raddr = mem_raddr;
                rd_count++;
                @(negedge clk);
                mem_addr_ok_r = 1'b0;
                repeat ($urandom % 4) @(negedge clk);
                check_bit("mem_rdy", mem_rdy, 1'b1);
                mem_rline   = mem_arr[raddr[9:4]];
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog: run did not finish within %0d ns", timeout_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////

    initial begin
        logic [31:0] addr;
        int          w0;
        int          r0;
        void'($urandom(65));
        rstn          = 1'b0;
        icache_req    = 1'b0;
        icache_addr   = '0;
        dcache_req    = 1'b0;
        dcache_wr     = 1'b0;
        dcache_addr   = '0;
        dcache_wdata  = '0;
        op_flag       = 1'b0;
        op_code       = l2_pkg::op_index_inv;
        op_addr       = '0;
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rline     = '0;
        for (int l = 0; l < 64; l++) begin
            for (int k = 0; k < 4; k++) begin
                mem_arr[l][k] = pattern(32'(l * 16 + k * 4));
            end
        end
        for (int w = 0; w < 256; w++) begin
            ref_mem[w] = pattern(32'(w * 4));
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        #1;

        check_bit("icache_addr_ok", icache_addr_ok, 1'b0);
        check_bit("dcache_addr_ok", dcache_addr_ok, 1'b0);
        check_bit("icache_data_ok", icache_data_ok, 1'b0);
        check_bit("dcache_data_ok", dcache_data_ok, 1'b0);
        check_bit("op_ack", op_ack, 1'b0);
        check_bit("mem_req_r", mem_req_r, 1'b0);
        check_bit("mem_req_w", mem_req_w, 1'b0);
        check_bit("mem_rdy", mem_rdy, 1'b0);
        close_test(1, "reset values");

        for (int i = 0; i < n_random; i++) begin
            addr = 32'($urandom % 128) << 2;   // 32 lines, 8 tags per set
            if ($urandom % 3 == 0) begin
                icache_read(addr);
            end else begin
                dcache_access($urandom % 2 == 1, addr, $urandom);
            end
        end
        close_test(2, "random access");

        dual_request(32'h0000_0024, 32'h0000_0158);
        close_test(3, "port priority");

        // empty set 1 so that four misses fill all ways
        for (int w = 0; w < 4; w++) begin
            cache_op(l2_pkg::op_index_wb_inv, 32'h0000_0010 | 32'(w));
        end
        settle();
        w0 = wb_count;
        for (int j = 0; j < 5; j++) begin
            addr = (32'(j + 3) << 6) | 32'h10 | (32'(j % 4) << 2);
            dcache_access(1'b1, addr, $urandom);
        end
        settle();
        check_bit("mem_req_w seen", wb_count != w0, 1'b1);
        for (int j = 0; j < 5; j++) begin
            addr = (32'(j + 3) << 6) | 32'h10 | (32'(j % 4) << 2);
            dcache_access(1'b0, addr, '0);
        end
        close_test(4, "dirty eviction");

        w0 = wb_count;
        cache_op(l2_pkg::op_hit_wb_inv, 32'h0002_0040);
        settle();
        check_bit("mem_req_w on uncached op", wb_count != w0, 1'b0);
        for (int s = 0; s < 4; s++) begin
            for (int w = 0; w < 4; w++) begin
                cache_op(l2_pkg::op_index_wb_inv, {26'd0, 2'(s), 2'b00, 2'(w)});
            end
        end
        settle();
        for (int l = 0; l < 64; l++) begin
            check_line("mem_line", mem_arr[l], model_line(32'(l * 16)));
        end
        close_test(5, "full flush");

        addr = 32'h0000_0094;
        r0   = rd_count;
        dcache_access(1'b0, addr, '0);
        check_bit("mem_req_r on cold read", rd_count != r0, 1'b1);
        r0 = rd_count;
        dcache_access(1'b0, addr, '0);
        check_bit("mem_req_r on hit", rd_count != r0, 1'b0);
        for (int w = 0; w < 4; w++) begin
            cache_op(l2_pkg::op_index_inv, {addr[31:4], 2'b00, 2'(w)});
        end
        r0 = rd_count;
        dcache_access(1'b0, addr, '0);
        check_bit("mem_req_r after index inv", rd_count != r0, 1'b1);
        dcache_access(1'b1, addr, $urandom);
        w0 = wb_count;
        cache_op(l2_pkg::op_hit_wb_inv, addr);
        settle();
        check_bit("mem_req_w after hit wb inv", wb_count != w0, 1'b1);
        r0 = rd_count;
        dcache_access(1'b0, addr, '0);
        check_bit("mem_req_r after hit wb inv", rd_count != r0, 1'b1);
        close_test(6, "invalidate ops");

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
logic/l2_pkg.sv
logic/l2_req_buf.sv
logic/l2_plru.sv
logic/l2_tag_store.sv
logic/l2_data_store.sv
logic/l2_fsm_main.sv
logic/l2_cache.sv
tb/tb_l2_cache.sv

/* Makefile */
.PHONY: run clean

run: obj_dir/Vtb_l2_cache
	@out=$$(./obj_dir/Vtb_l2_cache); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

obj_dir/Vtb_l2_cache: sim.f logic/*.sv tb/*.sv
	verilator --binary --assert -Wno-fatal --top-module tb_l2_cache -f sim.f -Mdir obj_dir

clean:
	rm -rf obj_dir
